//--- include/dout_rx_settings.svh
`ifndef DOUT_RX_SETTINGS_SVH
`define DOUT_RX_SETTINGS_SVH

// width of the bit-error counter
// saturates at all ones
`define DOUT_ERRCNT_WIDTH 16

// cycles the enable is stretched after it drops
// bit error checking stays off until this tail has passed
// must be at least 2 for the shift register form
`define DOUT_EN_TAIL 16

// APB register byte offsets, 12-bit address space
// CTRL: bit 0 enable, bit 1 capture strobe (reads 0)
`define DOUT_ADDR_CTRL 12'h000

// DATA: bits 7:0 stored byte, bit 8 new flag
`define DOUT_ADDR_DATA 12'h004

// ERRCNT: read the count, any write clears it
`define DOUT_ADDR_ERRCNT 12'h008

`endif

//--- rtl/dout_rx_pkg.sv
package dout_rx_pkg;

    // register block to capture block
    // 2 bits total
    typedef struct packed {
        // continuous capture while high
        logic enable;
        // one-cycle single capture request
        logic capture;
    } dout_ctrl_t;

    // capture block back to register block
    // 10 bits total
    typedef struct packed {
        // last byte taken from the link
        logic [7:0] data;
        // pulses for one cycle when data was updated
        logic       valid;
        // registered training mismatch flag
        logic       biterr;
    } dout_stat_t;

endpackage

//--- rtl/dout_phase_capture.sv
`timescale 1ns/100ps
`include "dout_rx_settings.svh"

module dout_phase_capture (
    input  logic                    sysclk_i,
    input  logic                    rst_n_i,
    input  logic                    sync_i,
    input  logic [7:0]              dout_i,
    input  dout_rx_pkg::dout_ctrl_t ctrl_i,
    output logic                    dout_sync_o,
    output dout_rx_pkg::dout_stat_t stat_o
);

    // two-cycle capture phase, forced to 0 by sync
    logic       phase_q;
    // strobe seen a second time, so a one-cycle request always hits phase 0
    logic       cap_rereg_q;
    // byte clock enable for the store
    logic       byte_ce_q;
    logic [7:0] store_q;
    logic       valid_q;
    // enable tail, replaces the vendor shift-register delay
    logic [`DOUT_EN_TAIL-1:0] en_dly_q;
    logic       en_delayed;
    // previous link byte, static training pattern so one stage is enough
    logic [7:0] dout_prev;
    logic       biterr_q;

    assign en_delayed = en_dly_q[`DOUT_EN_TAIL-1];

    // phase also resets the external serializer, keeps both aligned
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            phase_q <= 1'b0;
        end else if (sync_i) begin
            phase_q <= 1'b0;
        end else begin
            phase_q <= ~phase_q;
        end
    end

    // capture control
    // ce only set from phase 0, so the store always loads on phase 1 -> 0
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            cap_rereg_q <= 1'b0;
            byte_ce_q   <= 1'b0;
            valid_q     <= 1'b0;
            store_q     <= 8'h00;
        end else begin
            cap_rereg_q <= ctrl_i.capture;
            byte_ce_q   <= (ctrl_i.capture || cap_rereg_q || ctrl_i.enable) && !phase_q;
            valid_q     <= byte_ce_q;
            if (byte_ce_q) begin
                store_q <= dout_i;
            end
        end
    end

    // enable delay line
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            en_dly_q <= '0;
        end else begin
            en_dly_q <= {en_dly_q[`DOUT_EN_TAIL-2:0], ctrl_i.enable};
        end
    end

    // previous byte for the training compare, taken every cycle
    always_ff @(posedge sysclk_i) begin
        dout_prev <= dout_i;
    end

    // mismatch only checked when the link is idle and the tail has drained
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            biterr_q <= 1'b0;
        end else if (!ctrl_i.enable && !en_delayed) begin
            biterr_q <= (dout_i != dout_prev);
        end
    end

    assign dout_sync_o = phase_q;
    assign stat_o      = '{data: store_q, valid: valid_q, biterr: biterr_q};

    // back-to-back valids need a held sync three cycles earlier
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        valid_q && $past(valid_q) |-> $past(sync_i, 3));

    // valid ends on phase 1 unless a sync shifted the sequence in flight
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        $fell(valid_q) |-> phase_q || $past(sync_i) || $past(sync_i, 2) || $past(sync_i, 3));

endmodule

//--- rtl/dout_biterr_counter.sv
`timescale 1ns/100ps
`include "dout_rx_settings.svh"

module dout_biterr_counter #(
    parameter int WIDTH = `DOUT_ERRCNT_WIDTH
) (
    input  logic             sysclk_i,
    input  logic             rst_n_i,
    input  logic             biterr_i,
    input  logic             clear_i,
    output logic [WIDTH-1:0] count_o
);

    logic [WIDTH-1:0] count_q;
    // stop at all ones, a wrap would hide a bad link
    logic             at_max;

    assign at_max = &count_q;

    // clear has priority over a pending increment
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (biterr_i && !at_max) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

    // only a software clear may lower the count
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        !clear_i |=> count_q >= $past(count_q));

endmodule

//--- rtl/dout_apb_regs.sv
`timescale 1ns/100ps
`include "dout_rx_settings.svh"

module dout_apb_regs (
    input  logic                          sysclk_i,
    input  logic                          rst_n_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [11:0]                   paddr_i,
    input  logic [31:0]                   pwdata_i,
    input  dout_rx_pkg::dout_stat_t       stat_i,
    input  logic [`DOUT_ERRCNT_WIDTH-1:0] errcnt_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output dout_rx_pkg::dout_ctrl_t       ctrl_o,
    output logic                          errcnt_clear_o
);

    // access phase of an APB transfer
    logic access;
    logic wr_en;
    logic rd_en;
    // address decode
    logic hit_ctrl;
    logic hit_data;
    logic hit_errcnt;
    logic addr_ok;

    // enable bit plus the capture strobe
    dout_rx_pkg::dout_ctrl_t ctrl_q;
    logic                    clear_q;
    // set by valid, cleared by reading DATA
    logic                    new_q;

    assign access     = psel_i && penable_i;
    assign wr_en      = access && pwrite_i;
    assign rd_en      = access && !pwrite_i;

    assign hit_ctrl   = (paddr_i == `DOUT_ADDR_CTRL);
    assign hit_data   = (paddr_i == `DOUT_ADDR_DATA);
    assign hit_errcnt = (paddr_i == `DOUT_ADDR_ERRCNT);
    assign addr_ok    = hit_ctrl || hit_data || hit_errcnt;

    // never waits, every transfer finishes in its access phase
    assign pready_o   = 1'b1;
    assign pslverr_o  = access && !addr_ok;

    // control register and strobes
    // strobes last exactly the cycle after the access phase
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= '0;
            clear_q <= 1'b0;
        end else begin
            if (wr_en && hit_ctrl) begin
                ctrl_q.enable <= pwdata_i[0];
            end
            ctrl_q.capture <= wr_en && hit_ctrl && pwdata_i[1];
            // data value ignored on ERRCNT, any write clears
            clear_q        <= wr_en && hit_errcnt;
        end
    end

    // new flag, set wins over a clear in the same cycle
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            new_q <= 1'b0;
        end else if (stat_i.valid) begin
            new_q <= 1'b1;
        end else if (rd_en && hit_data) begin
            new_q <= 1'b0;
        end
    end

    // read mux
    // capture bit reads back as 0
    always_comb begin
        prdata_o = 32'h0000_0000;
        if (hit_ctrl) begin
            prdata_o = {31'h0, ctrl_q.enable};
        end else if (hit_data) begin
            prdata_o = {23'h0, new_q, stat_i.data};
        end else if (hit_errcnt) begin
            prdata_o = 32'(errcnt_i);
        end
    end

    assign ctrl_o         = ctrl_q;
    assign errcnt_clear_o = clear_q;

    // APB needs a setup phase between transfers, so no two strobes in a row
    assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        ctrl_q.capture |=> !ctrl_q.capture);

endmodule

//--- rtl/dout_rx_top.sv
`timescale 1ns/100ps
`include "dout_rx_settings.svh"

module dout_rx_top (
    input  logic        sysclk_i,
    input  logic        rst_n_i,
    input  logic        sync_i,
    input  logic [7:0]  dout_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic        dout_sync_o,
    output logic        dout_biterr_o,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);

    dout_rx_pkg::dout_ctrl_t       ctrl;
    dout_rx_pkg::dout_stat_t       stat;
    logic [`DOUT_ERRCNT_WIDTH-1:0] errcnt;
    logic                          errcnt_clear;

    // phase generator, byte store and training check
    dout_phase_capture i_capture (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .sync_i      (sync_i),
        .dout_i      (dout_i),
        .ctrl_i      (ctrl),
        .dout_sync_o (dout_sync_o),
        .stat_o      (stat)
    );

    // counts cycles with the mismatch flag up
    dout_biterr_counter #(
        .WIDTH (`DOUT_ERRCNT_WIDTH)
    ) i_errcnt (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .biterr_i (stat.biterr),
        .clear_i  (errcnt_clear),
        .count_o  (errcnt)
    );

    // software access
    dout_apb_regs i_regs (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .stat_i         (stat),
        .errcnt_i       (errcnt),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .ctrl_o         (ctrl),
        .errcnt_clear_o (errcnt_clear)
    );

    assign dout_biterr_o = stat.biterr;

endmodule

//--- verification/dout_rx_tb.sv
`timescale 1ns/100ps
`include "dout_rx_settings.svh"

module dout_rx_tb;

    // full sequence runs a few hundred cycles, limit keeps a wide margin
    localparam int MAX_CYCLES = 4000;

    logic        sysclk = 1'b0;
    logic        rst_n;
    logic        sync;
    logic [7:0]  dout;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic        dout_sync;
    logic        dout_biterr;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // reference model state
    logic [31:0] exp_rdata;
    logic        exp_slverr;
    // expected mismatch flag, high for one cycle after a counted change
    logic        exp_flag;
    logic [7:0]  train_byte;
    logic [7:0]  held_byte;
    int          exp_cnt = 0;
    int          err_cnt = 0;
    int          rd_cnt = 0;
    int          cycle_cnt = 0;
    int unsigned seed_ret;

    always #20 sysclk = ~sysclk;

    dout_rx_top i_dut (
        .sysclk_i      (sysclk),
        .rst_n_i       (rst_n),
        .sync_i        (sync),
        .dout_i        (dout),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .dout_sync_o   (dout_sync),
        .dout_biterr_o (dout_biterr),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr)
    );

    // read data against the model in the access phase
    assert property (@(posedge sysclk) disable iff (!rst_n)
        psel && penable && !pwrite |-> prdata == exp_rdata)
    else begin
        err_cnt++;
        $display("** Error @%0t: prdata_o = %h, expected %h",
            $time, $sampled(prdata), $sampled(exp_rdata));
    end

    assert property (@(posedge sysclk) disable iff (!rst_n)
        psel && penable |-> pslverr == exp_slverr)
    else begin
        err_cnt++;
        $display("** Error @%0t: pslverr_o = %b, expected %b",
            $time, $sampled(pslverr), $sampled(exp_slverr));
    end

    assert property (@(posedge sysclk) disable iff (!rst_n)
        psel && penable |-> pready)
    else begin
        err_cnt++;
        $display("access phase at %0t saw pready_o low, transfer would stall", $time);
    end

    // mismatch flag against the model every cycle
    assert property (@(posedge sysclk) disable iff (!rst_n)
        dout_biterr == exp_flag)
    else begin
        err_cnt++;
        $display("** Error @%0t: dout_biterr_o = %b, expected %b",
            $time, $sampled(dout_biterr), $sampled(exp_flag));
    end

    // sync forces phase 0 one cycle later
    assert property (@(posedge sysclk) disable iff (!rst_n)
        sync |=> !dout_sync)
    else begin
        err_cnt++;
        $display("** Error @%0t: dout_sync_o = %b, expected 0", $time, $sampled(dout_sync));
    end

    // free running phase alternates
    assert property (@(posedge sysclk) disable iff (!rst_n)
        !sync |=> dout_sync != $past(dout_sync))
    else begin
        err_cnt++;
        $display("** Error @%0t: dout_sync_o = %b, expected %b",
            $time, $sampled(dout_sync), !$sampled(dout_sync));
    end

    // cycle limit and read count
    always @(posedge sysclk) begin
        cycle_cnt++;
        if (psel && penable && !pwrite) begin
            rd_cnt++;
        end
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic err);
        @(negedge sysclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge sysclk);
        penable    = 1'b1;
        exp_slverr = err;
        @(negedge sysclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp,
                            input logic err);
        @(negedge sysclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge sysclk);
        penable    = 1'b1;
        exp_rdata  = exp;
        exp_slverr = err;
        @(negedge sysclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // one step on the training byte, then hold it
    // flag is up for the cycle after the step when checking is active
    task automatic change_byte(input logic counts);
        logic [7:0] flip;
        flip = 8'($urandom()) | 8'h01;
        @(negedge sysclk);
        dout = dout ^ flip;
        @(negedge sysclk);
        if (counts) begin
            exp_cnt++;
            exp_flag = 1'b1;
        end
        @(negedge sysclk);
        exp_flag = 1'b0;
        wait_cycles(1);
    endtask

    initial begin
        seed_ret   = $urandom(32'hec4d_f7ce);
        train_byte = 8'($urandom());
        rst_n      = 1'b0;
        sync       = 1'b0;
        dout       = train_byte;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 12'h000;
        pwdata     = 32'h0;
        exp_rdata  = 32'h0;
        exp_slverr = 1'b0;
        exp_flag   = 1'b0;
        held_byte  = 8'h00;
        repeat (8) @(negedge sysclk);
        rst_n = 1'b1;
        wait_cycles(2);

        // reset values
        apb_read(`DOUT_ADDR_CTRL, 32'h0, 1'b0);
        apb_read(`DOUT_ADDR_DATA, 32'h0, 1'b0);
        apb_read(`DOUT_ADDR_ERRCNT, 32'h0, 1'b0);

        // single capture of the byte on the link, new flag cleared by the read
        apb_write(`DOUT_ADDR_CTRL, 32'h2, 1'b0);
        wait_cycles(6);
        apb_read(`DOUT_ADDR_DATA, {23'h0, 1'b1, train_byte}, 1'b0);
        apb_read(`DOUT_ADDR_DATA, {23'h0, 1'b0, train_byte}, 1'b0);
        apb_read(`DOUT_ADDR_CTRL, 32'h0, 1'b0);

        // training check, one change then several with gaps
        wait_cycles(10);
        apb_read(`DOUT_ADDR_ERRCNT, 32'h0, 1'b0);
        change_byte(1'b1);
        wait_cycles(4);
        apb_read(`DOUT_ADDR_ERRCNT, exp_cnt, 1'b0);
        repeat (5) begin
            change_byte(1'b1);
            wait_cycles(4);
        end
        apb_read(`DOUT_ADDR_ERRCNT, exp_cnt, 1'b0);
        apb_write(`DOUT_ADDR_ERRCNT, 32'hffff_ffff, 1'b0);
        exp_cnt = 0;
        apb_read(`DOUT_ADDR_ERRCNT, 32'h0, 1'b0);

        // enable window, changes while on and inside the tail are ignored
        apb_write(`DOUT_ADDR_CTRL, 32'h1, 1'b0);
        repeat (3) begin
            change_byte(1'b0);
            wait_cycles(2);
        end
        apb_read(`DOUT_ADDR_CTRL, 32'h1, 1'b0);
        held_byte = dout;
        apb_write(`DOUT_ADDR_CTRL, 32'h0, 1'b0);
        wait_cycles(2);
        change_byte(1'b0);
        wait_cycles(`DOUT_EN_TAIL + 8);
        apb_read(`DOUT_ADDR_ERRCNT, 32'h0, 1'b0);
        change_byte(1'b1);
        wait_cycles(4);
        apb_read(`DOUT_ADDR_ERRCNT, exp_cnt, 1'b0);
        // last continuous load happened just after enable dropped
        apb_read(`DOUT_ADDR_DATA, {23'h0, 1'b1, held_byte}, 1'b0);

        // phase realignment, single and held sync
        @(negedge sysclk);
        sync = 1'b1;
        @(negedge sysclk);
        sync = 1'b0;
        wait_cycles(5);
        change_byte(1'b1);
        @(negedge sysclk);
        sync = 1'b1;
        wait_cycles(3);
        sync = 1'b0;
        apb_write(`DOUT_ADDR_CTRL, 32'h2, 1'b0);
        wait_cycles(6);
        apb_read(`DOUT_ADDR_DATA, {23'h0, 1'b1, dout}, 1'b0);

        // unmapped offset, error response and no side effects
        apb_write(12'h00C, 32'hffff_ffff, 1'b1);
        apb_read(12'h00C, 32'h0, 1'b1);
        apb_read(`DOUT_ADDR_CTRL, 32'h0, 1'b0);
        apb_read(`DOUT_ADDR_DATA, {23'h0, 1'b0, dout}, 1'b0);
        apb_read(`DOUT_ADDR_ERRCNT, exp_cnt, 1'b0);

        wait_cycles(4);
        $display("summary: %0d reads checked, %0d errors", rd_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
rtl/dout_rx_pkg.sv
rtl/dout_phase_capture.sv
rtl/dout_biterr_counter.sv
rtl/dout_apb_regs.sv
rtl/dout_rx_top.sv
verification/dout_rx_tb.sv

//--- Makefile
# Verilator build and run of the receive path testbench

VERILATOR ?= verilator
TOP       ?= dout_rx_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

# build, run, and fail unless the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
